// ==== hdl/histAccumulator.sv ====
`timescale 1ns/10ps

module histAccumulator import histPkg::*; (
    input  logic  clk,
    input  logic  res,
    input  logic  clearStart,
    input  eventT eventIn,
    input  logic  eventValid,
    output logic  eventReady,
    output logic  busy,
    output wbReqT bus,
    input  wbRspT busRsp
);

    typedef enum logic [2:0] {
        IDLE,
        CLEARING,
        READ,
        WRITE,
        RELEASE
    } stateT;

    // first write of the clear sweep
    localparam wbReqT CLEAR_FIRST = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: '0, dat: '0};
    localparam addrT LAST_ADDR = addrT'(NUM_ADDR - 1);

    stateT state;
    logic  clearPending;    // clear arrived in the same cycle as an event
    logic  accept;
    countT bumped;

    assign accept = eventValid && eventReady;

    // saturating increment of the bin just read
    assign bumped = (busRsp.dat == COUNT_MAX) ? COUNT_MAX : busRsp.dat + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            clearPending <= 1'b0;
            eventReady <= 1'b0;
            busy <= 1'b0;
            bus <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        // event wins the cycle, a simultaneous clear waits
                        state <= READ;
                        clearPending <= clearStart;
                        eventReady <= 1'b0;
                        busy <= 1'b1;
                        bus.cyc <= 1'b1;
                        bus.stb <= 1'b1;
                        bus.we <= 1'b0;
                        bus.adr <= {eventIn.pixel, eventIn.bin};
                    end else if (clearStart) begin
                        state <= CLEARING;
                        eventReady <= 1'b0;
                        busy <= 1'b1;
                        bus <= CLEAR_FIRST;
                    end else begin
                        eventReady <= 1'b1;     // also the first raise after reset
                    end
                end
                CLEARING: begin
                    if (busRsp.ack) begin
                        if (bus.adr == LAST_ADDR) begin
                            state <= RELEASE;
                            bus.cyc <= 1'b0;
                            bus.stb <= 1'b0;
                            bus.we <= 1'b0;
                        end else begin
                            bus.adr <= bus.adr + 1'b1;  // stb stays up
                        end
                    end
                end
                READ: begin
                    if (busRsp.ack) begin
                        state <= WRITE;
                        bus.we <= 1'b1;         // same address, cyc held
                        bus.dat <= bumped;
                    end
                end
                WRITE: begin
                    if (busRsp.ack) begin
                        state <= RELEASE;
                        bus.cyc <= 1'b0;
                        bus.stb <= 1'b0;
                        bus.we <= 1'b0;
                    end
                end
                RELEASE: begin
                    // one cycle with cyc low lets the peak finder in
                    if (clearPending) begin
                        state <= CLEARING;
                        clearPending <= 1'b0;
                        bus <= CLEAR_FIRST;
                    end else begin
                        state <= IDLE;
                        busy <= 1'b0;
                        eventReady <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // an ack only answers a strobe this engine still holds
    ackNeedsStb: assert property (
        @(posedge clk) disable iff (!res)
        busRsp.ack |-> bus.stb
    );

endmodule

// ==== hdl/histPkg.sv ====
package histPkg;

    // histogram geometry
    localparam int PIXEL_W = 2;                 // 4 pixels
    localparam int BIN_W = 4;                   // 16 bins per pixel
    localparam int COUNT_W = 8;
    localparam int ADDR_W = PIXEL_W + BIN_W;
    localparam int NUM_ADDR = 1 << ADDR_W;      // whole memory depth

    typedef logic [PIXEL_W-1:0] pixelT;
    typedef logic [BIN_W-1:0] binT;
    typedef logic [COUNT_W-1:0] countT;
    typedef logic [ADDR_W-1:0] addrT;          // {pixel, bin}

    localparam countT COUNT_MAX = '1;           // counts stick here

    // one photon event
    typedef struct packed {
        pixelT pixel;
        binT   bin;
    } eventT;

    // peak search result
    typedef struct packed {
        binT   bin;
        countT count;
    } peakT;

    // wishbone master side
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addrT  adr;
        countT dat;
    } wbReqT;

    // wishbone slave side
    typedef struct packed {
        logic  ack;
        countT dat;                             // valid with ack
    } wbRspT;

endpackage

// ==== hdl/histRam.sv ====
`timescale 1ns/10ps

module histRam import histPkg::*; (
    input  logic  clk,
    input  logic  res,
    input  wbReqT req,
    output wbRspT rsp
);

    countT mem [NUM_ADDR];  // contents undefined until the first clear
    logic  access;
    logic  ackReg;
    countT rdData;

    // ack in flight blocks a second sample of the same strobe
    assign access = req.cyc && req.stb && !ackReg;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ackReg <= 1'b0;
        end else begin
            ackReg <= access;       // one cycle after stb
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req.we) begin
                mem[req.adr] <= req.dat;
            end
            rdData <= mem[req.adr];     // old value on a write, unused then
        end
    end

    assign rsp = '{ack: ackReg, dat: rdData};

    // the arbiter forwards a strobe only from an owner that holds cyc
    stbNeedsCyc: assert property (
        @(posedge clk) disable iff (!res)
        req.stb |-> req.cyc
    );

endmodule

// ==== hdl/histTop.sv ====
`timescale 1ns/10ps

module histTop import histPkg::*; (
    input  logic  clk,
    input  logic  res,
    input  eventT eventIn,
    input  logic  eventValid,
    output logic  eventReady,
    input  logic  clearStart,
    output logic  busy,
    input  logic  peakReq,
    input  pixelT peakPixel,
    output logic  peakDone,
    output peakT  peakOut
);

    // engine to arbiter
    wbReqT accReq;
    wbRspT accRsp;
    wbReqT pfReq;
    wbRspT pfRsp;

    // arbiter to memory
    wbReqT ramReq;
    wbRspT ramRsp;

    histAccumulator accumulator (
        .clk        (clk),
        .res        (res),
        .clearStart (clearStart),
        .eventIn    (eventIn),
        .eventValid (eventValid),
        .eventReady (eventReady),
        .busy       (busy),
        .bus        (accReq),
        .busRsp     (accRsp)
    );

    peakFinder finder (
        .clk       (clk),
        .res       (res),
        .peakReq   (peakReq),
        .peakPixel (peakPixel),
        .peakDone  (peakDone),
        .peakOut   (peakOut),
        .bus       (pfReq),
        .busRsp    (pfRsp)
    );

    // accumulator has priority on the shared memory
    wbArbiter arbiter (
        .clk    (clk),
        .res    (res),
        .accReq (accReq),
        .accRsp (accRsp),
        .pfReq  (pfReq),
        .pfRsp  (pfRsp),
        .ramReq (ramReq),
        .ramRsp (ramRsp)
    );

    histRam ram (
        .clk (clk),
        .res (res),
        .req (ramReq),
        .rsp (ramRsp)
    );

endmodule

// ==== hdl/peakFinder.sv ====
`timescale 1ns/10ps

module peakFinder import histPkg::*; (
    input  logic  clk,
    input  logic  res,
    input  logic  peakReq,
    input  pixelT peakPixel,
    output logic  peakDone,
    output peakT  peakOut,
    output wbReqT bus,
    input  wbRspT busRsp
);

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } stateT;

    stateT state;
    pixelT pixel;       // latched at request
    binT   curBin;      // bin whose read is on the bus
    binT   nextBin;
    logic  lastBin;
    logic  better;
    logic  start;

    assign start = (state == IDLE) && peakReq;
    assign nextBin = curBin + 1'b1;
    assign lastBin = (curBin == '1);

    // strict compare so a tie keeps the earlier bin
    assign better = busRsp.dat > peakOut.count;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            curBin <= '0;
            peakDone <= 1'b0;
            bus <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (peakReq) begin
                        state <= SCAN;
                        curBin <= '0;
                        bus.cyc <= 1'b1;     // held for the whole scan
                        bus.stb <= 1'b1;
                        bus.we <= 1'b0;
                        bus.adr <= {peakPixel, binT'(0)};
                    end
                end
                SCAN: begin
                    if (busRsp.ack) begin
                        if (lastBin) begin
                            state <= DONE;
                            peakDone <= 1'b1;
                            bus.cyc <= 1'b0;
                            bus.stb <= 1'b0;
                        end else begin
                            curBin <= nextBin;
                            bus.adr <= {pixel, nextBin};
                        end
                    end
                end
                DONE: begin
                    peakDone <= 1'b0;       // single pulse
                    if (!peakReq) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // running maximum, the output doubles as the result register
    always_ff @(posedge clk) begin
        if (start) begin
            pixel <= peakPixel;
            peakOut <= '{bin: '0, count: '0};
        end else if (state == SCAN && busRsp.ack && better) begin
            peakOut <= '{bin: curBin, count: busRsp.dat};
        end
    end

endmodule

// ==== hdl/wbArbiter.sv ====
`timescale 1ns/10ps

module wbArbiter import histPkg::*; (
    input  logic  clk,
    input  logic  res,
    input  wbReqT accReq,
    output wbRspT accRsp,
    input  wbReqT pfReq,
    output wbRspT pfRsp,
    output wbReqT ramReq,
    input  wbRspT ramRsp
);

    logic grantPf;      // low hands the memory to the accumulator
    logic ownerCyc;

    assign ownerCyc = grantPf ? pfReq.cyc : accReq.cyc;

    // grant locks while the owner holds cyc, so a read/write-back pair
    // from the accumulator can't be split by a peak scan
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            grantPf <= 1'b0;
        end else if (!ownerCyc) begin
            if (accReq.cyc) begin
                grantPf <= 1'b0;        // accumulator first
            end else if (pfReq.cyc) begin
                grantPf <= 1'b1;
            end
        end
    end

    assign ramReq = grantPf ? pfReq : accReq;

    // read data goes to both, ack only to the owner
    always_comb begin
        accRsp = ramRsp;
        pfRsp = ramRsp;
        accRsp.ack = ramRsp.ack && !grantPf;
        pfRsp.ack = ramRsp.ack && grantPf;
    end

    // the memory only acks while the owner still strobes
    ackInCycle: assert property (
        @(posedge clk) disable iff (!res)
        ramRsp.ack |-> (ramReq.cyc && ramReq.stb)
    );

endmodule

// ==== sources.f ====
hdl/histPkg.sv
hdl/histRam.sv
hdl/wbArbiter.sv
hdl/histAccumulator.sv
hdl/peakFinder.sv
hdl/histTop.sv
testbench/histChecker.sv
testbench/histTb.sv

// ==== testbench/histChecker.sv ====
`timescale 1ns/10ps

module histChecker import histPkg::*; (
    input  logic clk,
    input  logic res,
    input  logic peakDone,
    input  peakT peakOut,
    input  logic busy,
    input  logic eventReady,
    output int   passCount,
    output int   failCount,
    output int   flowErrors,
    output logic timedOut
);

    localparam STIM_FILE = "testbench/histStimulus.txt";

    int    fd;
    int    lineNo;
    int    fields;
    int    argA;
    int    argB;
    int    argC;
    logic [7:0] cmd;
    string line;
    int    cycles;
    int    limit;
    logic  readySeen;   // eventReady has come up once since reset

    // expected peaks in query order
    binT   expBin[$];
    countT expCount[$];
    int    expLine[$];

    initial begin
        passCount = 0;
        failCount = 0;
        flowErrors = 0;
        timedOut = 1'b0;
        readySeen = 1'b0;
        cycles = 0;
        lineNo = 0;
        limit = 200;    // reset and drain margin
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: checker could not open %s", STIM_FILE);
            failCount++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    lineNo++;
                    fields = $sscanf(line, "%c %d %d %d", cmd, argA, argB, argC);
                    if (cmd == "C") begin
                        limit += 300;
                    end else if (cmd == "E" && fields == 4) begin
                        limit += 8 * argC;
                    end else if (cmd == "P" && fields == 4) begin
                        limit += 40;
                        expBin.push_back(binT'(argB));
                        expCount.push_back(countT'(argC));
                        expLine.push_back(lineNo);
                    end
                end
            end
            $fclose(fd);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (!timedOut && cycles >= limit) begin
            $display("ERROR: run timed out waiting for results after %0d cycles", cycles);
            timedOut = 1'b1;
        end
    end

    // past the first ready, busy and eventReady are complements
    always @(negedge clk) begin
        if (!res) begin
            readySeen = 1'b0;
        end else begin
            if (readySeen && busy === eventReady) begin
                $display("ERROR: busy and eventReady are both %b at %0t", busy, $time);
                flowErrors++;
            end
            if (eventReady) begin
                readySeen = 1'b1;
            end
        end
    end

    // peakDone and peakOut are registered, steady at the falling edge
    always @(negedge clk) begin
        if (res && peakDone) begin
            if (expBin.size() == 0) begin
                $display("ERROR: peak result arrived with no query left to check");
                failCount++;
            end else if (peakOut.bin !== expBin[0] || peakOut.count !== expCount[0]) begin
                $display("Mismatch P%0d: expected bin %0d count %0d, actual bin %0d count %0d",
                         expLine[0], expBin[0], expCount[0], peakOut.bin, peakOut.count);
                failCount++;
            end else begin
                $display("Pass P%0d: bin %0d count %0d", expLine[0], peakOut.bin, peakOut.count);
                passCount++;
            end
            if (expBin.size() > 0) begin
                void'(expBin.pop_front());
                void'(expCount.pop_front());
                void'(expLine.pop_front());
            end
        end
    end

endmodule

// ==== testbench/histStimulus.txt ====
# C = clear, E pixel bin repeat = send events, P pixel expBin expCount = peak query
# values are decimal, a query is named P plus its line number
C
P 0 0 0
P 1 0 0
P 2 0 0
P 3 0 0
E 1 5 7
P 1 5 7
E 0 3 4
E 2 9 6
E 3 14 2
E 0 12 5
P 0 12 5
P 2 9 6
P 3 14 2
E 3 2 2
P 3 2 2
E 1 11 7
P 1 5 7
E 2 0 300
P 2 0 255
E 0 7 3
P 0 12 5
E 1 11 1
P 1 11 8
C
P 0 0 0
P 1 0 0
P 2 0 0
P 3 0 0

// ==== testbench/histTb.sv ====
`timescale 1ns/10ps

module histTb import histPkg::*; ();

    localparam STIM_FILE = "testbench/histStimulus.txt";
    localparam int DRIVE_DELAY = 2;     // ns after the rising edge

    logic  clk;
    logic  res;
    eventT eventIn;
    logic  eventValid;
    logic  eventReady;
    logic  clearStart;
    logic  busy;
    logic  peakReq;
    pixelT peakPixel;
    logic  peakDone;
    peakT  peakOut;

    int    passCount;
    int    failCount;
    int    flowErrors;
    logic  timedOut;
    int    queries;         // peak queries driven so far
    int    stimErrors;
    int    fd;
    int    lineNo;
    int    fields;
    int    argA;
    int    argB;
    int    argC;
    logic [7:0] cmd;
    string line;

    histTop DUT (
        .clk        (clk),
        .res        (res),
        .eventIn    (eventIn),
        .eventValid (eventValid),
        .eventReady (eventReady),
        .clearStart (clearStart),
        .busy       (busy),
        .peakReq    (peakReq),
        .peakPixel  (peakPixel),
        .peakDone   (peakDone),
        .peakOut    (peakOut)
    );

    histChecker resultCheck (
        .clk        (clk),
        .res        (res),
        .peakDone   (peakDone),
        .peakOut    (peakOut),
        .busy       (busy),
        .eventReady (eventReady),
        .passCount  (passCount),
        .failCount  (failCount),
        .flowErrors (flowErrors),
        .timedOut   (timedOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic nextCycle;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic sendEvent(input int pixel, input int bin);
        eventIn = '{pixel: pixelT'(pixel), bin: binT'(bin)};
        eventValid = 1'b1;
        while (!eventReady) begin   // registered, so stable until the next edge
            nextCycle();
        end
        nextCycle();                // handshake on this edge
        eventValid = 1'b0;
    endtask

    task automatic sendEvents(input int pixel, input int bin, input int count);
        int i;
        int gap;
        for (i = 0; i < count; i++) begin
            sendEvent(pixel, bin);
            gap = $urandom % 4;
            repeat (gap) begin
                nextCycle();
            end
        end
    endtask

    task automatic runClear;
        while (busy) begin
            nextCycle();
        end
        clearStart = 1'b1;
        nextCycle();
        clearStart = 1'b0;
        while (busy) begin          // whole sweep
            nextCycle();
        end
    endtask

    task automatic runPeak(input int pixel);
        while (busy || !eventReady) begin
            nextCycle();
        end
        peakPixel = pixelT'(pixel);
        peakReq = 1'b1;
        while (!peakDone) begin
            nextCycle();
        end
        peakReq = 1'b0;
        nextCycle();                // finder sees the request drop
        queries++;
    endtask

    task automatic runLine;
        fields = $sscanf(line, "%c %d %d %d", cmd, argA, argB, argC);
        case (cmd)
            "C": runClear();
            "E", "P": begin
                if (fields < 4) begin
                    $display("ERROR: stimulus line %0d is missing fields", lineNo);
                    stimErrors++;
                end else if (cmd == "E") begin
                    sendEvents(argA, argB, argC);
                end else begin
                    runPeak(argA);
                end
            end
            "#", 8'd9, 8'd10, 8'd13, 8'd32: ;  // comments and blank lines
            default: begin
                $display("ERROR: unknown command on stimulus line %0d", lineNo);
                stimErrors++;
            end
        endcase
    endtask

    initial begin
        res = 1'b0;
        eventIn = '0;
        eventValid = 1'b0;
        clearStart = 1'b0;
        peakReq = 1'b0;
        peakPixel = '0;
        queries = 0;
        stimErrors = 0;
        lineNo = 0;
        void'($urandom(83167));
        repeat (2) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        res = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: stimulus file %s could not be opened", STIM_FILE);
            stimErrors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    lineNo++;
                    runLine();
                end
            end
            $fclose(fd);
        end
        repeat (4) begin
            nextCycle();
        end
        if (passCount + failCount != queries) begin
            $display("ERROR: %0d peak queries sent but %0d results checked",
                     queries, passCount + failCount);
            stimErrors++;
        end
        $display("Summary: %0d passed, %0d failed, %0d other errors",
                 passCount, failCount, stimErrors + flowErrors);
        if (failCount == 0 && stimErrors == 0 && flowErrors == 0 && queries > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // checker flags a run that stalls
    initial begin
        wait (timedOut);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
